// File: source/cm_pkg.sv
`default_nettype none

package cm_pkg;

   // ORT size
   localparam int tag_count = 16;
   localparam int tag_bits  = 4;

   // header codes for a completion with data
   localparam logic [1:0] fmt_cpl_data = 2'b10;
   localparam logic [4:0] type_cpl     = 5'b01010;
   localparam logic [2:0] status_ok    = 3'b000;

   // ---------------------------------------------------------------------
   // field positions, header beat 1
   // ---------------------------------------------------------------------
   localparam int hdr_fmt_lsb    = 61;
   localparam int hdr_type_lsb   = 56;
   localparam int hdr_status_lsb = 13;
   localparam int hdr_len_lsb    = 32;
   localparam int hdr_bcount_lsb = 0;

   // ---------------------------------------------------------------------
   // field positions, header beat 2
   // ---------------------------------------------------------------------
   localparam int hdr_tag_lsb     = 40;
   localparam int hdr_lowaddr_lsb = 32;

   typedef enum logic [1:0] {
      st_header1 = 2'd0,
      st_header2 = 2'd1,
      st_body    = 2'd2
   } rx_state_t;

   typedef enum logic [1:0] {
      op_wr_odd  = 2'd0,
      op_wr_even = 2'd1,
      op_drop    = 2'd2
   } cpl_op_t;

   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_first = 2'd1,
      cmd_body  = 2'd2
   } wr_cmd_t;

endpackage

`default_nettype wire

// File: source/ort_table.sv
`timescale 1ns/100ps
`default_nettype none

module ort_table #(
   parameter int mem_addr_bits = 16
) (
   input  logic                        pcie_clk,
   input  logic                        rst,
   input  logic                        ort_req_v,
   input  logic [cm_pkg::tag_bits-1:0] ort_req_tag,
   input  logic [mem_addr_bits-1:0]    ort_req_addr,
   input  logic [cm_pkg::tag_bits-1:0] lookup_tag,
   input  logic                        upd_v,
   input  logic [cm_pkg::tag_bits-1:0] upd_tag,
   input  logic [mem_addr_bits-1:0]    upd_addr,
   input  logic                        free_v,
   input  logic [cm_pkg::tag_bits-1:0] free_tag,
   output logic [mem_addr_bits-1:0]    lookup_addr,
   output logic                        ort_next_tag_v,
   output logic [cm_pkg::tag_bits-1:0] ort_next_tag,
   output logic                        cfg_trn_pending_n
);
   import cm_pkg::*;

   logic [tag_count-1:0]     valid;
   logic [mem_addr_bits-1:0] addr_mem [tag_count];

   assign lookup_addr = addr_mem[lookup_tag];

   // ---------------------------------------------------------------------
   // free tag search
   // ---------------------------------------------------------------------
   // highest index wins, the tag being claimed right now is skipped
   always_comb begin
      ort_next_tag_v = 1'b0;
      ort_next_tag   = '0;
      for (int i = 0; i < tag_count; i++) begin
         if (!valid[i] && !(ort_req_v && ort_req_tag == tag_bits'(i))) begin
            ort_next_tag_v = 1'b1;
            ort_next_tag   = tag_bits'(i);
         end
      end
   end

   // ---------------------------------------------------------------------
   // entry state
   // ---------------------------------------------------------------------
   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         valid             <= '0;
         cfg_trn_pending_n <= 1'b1;
      end else begin
         cfg_trn_pending_n <= ~|valid;
         if (free_v) begin
            valid[free_tag] <= 1'b0;
         end
         if (ort_req_v) begin
            valid[ort_req_tag] <= 1'b1;
         end
      end
   end

   // a new request overrides a continuation update on the same tag
   always_ff @(posedge pcie_clk) begin
      if (upd_v) begin
         addr_mem[upd_tag] <= upd_addr;
      end
      if (ort_req_v) begin
         addr_mem[ort_req_tag] <= ort_req_addr;
      end
   end

   // requester must only reuse a tag after its final completion
   a_req_tag_free : assert property (@(posedge pcie_clk) disable iff (rst)
      ort_req_v |-> !valid[ort_req_tag]);

endmodule

`default_nettype wire

// File: source/cpl_parser.sv
`timescale 1ns/100ps
`default_nettype none

module cpl_parser #(
   parameter int mem_addr_bits = 16
) (
   input  logic                        pcie_clk,
   input  logic                        rst,
   input  logic [63:0]                 trn_rd,
   input  logic [7:0]                  trn_rrem_n,
   input  logic                        trn_rsof_n,
   input  logic                        trn_reof_n,
   input  logic                        trn_rsrc_rdy_n,
   input  logic                        trn_rerrfwd_n,
   input  logic [mem_addr_bits-1:0]    lookup_addr,
   output logic [cm_pkg::tag_bits-1:0] lookup_tag,
   output logic                        upd_v,
   output logic [cm_pkg::tag_bits-1:0] upd_tag,
   output logic [mem_addr_bits-1:0]    upd_addr,
   output logic                        free_v,
   output logic [cm_pkg::tag_bits-1:0] free_tag,
   output cm_pkg::wr_cmd_t             cmd,
   output logic [63:0]                 cmd_data,
   output logic [mem_addr_bits-1:0]    cmd_addr,
   output logic [3:0]                  cmd_first_be,
   output logic [3:0]                  cmd_last_be,
   output logic                        cmd_last,
   output logic                        cmd_half,
   output logic                        stat_cpl_inc,
   output logic                        stat_err_inc
);
   import cm_pkg::*;

   // ---------------------------------------------------------------------
   // input register stage
   // ---------------------------------------------------------------------
   logic [63:0] rd_q;
   logic [7:0]  rrem_n_q;
   logic        sof_n_q;
   logic        eof_n_q;
   logic        src_rdy_n_q;
   logic        errfwd_n_q;

   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         src_rdy_n_q <= 1'b1;
      end else begin
         src_rdy_n_q <= trn_rsrc_rdy_n;
      end
      rd_q       <= trn_rd;
      rrem_n_q   <= trn_rrem_n;
      sof_n_q    <= trn_rsof_n;
      eof_n_q    <= trn_reof_n;
      errfwd_n_q <= trn_rerrfwd_n;
   end

   rx_state_t   state;
   cpl_op_t     op;
   logic [63:0] head1;
   logic        beat_v;
   logic        in_hdr2;
   logic        is_cpl;
   logic        cpl_good;
   logic        cpl_err;
   logic        is_final;
   logic [10:0] len_dw;
   logic [12:0] bcount_b;
   logic [1:0]  low_addr;
   logic [3:0]  first_be;
   logic [3:0]  last_be;

   assign beat_v  = !src_rdy_n_q && errfwd_n_q;
   assign in_hdr2 = beat_v && (state == st_header2);

   // ---------------------------------------------------------------------
   // completion decode
   // ---------------------------------------------------------------------
   assign is_cpl = (head1[hdr_fmt_lsb +: 2] == fmt_cpl_data)
                && (head1[hdr_type_lsb +: 5] == type_cpl);
   assign cpl_good = in_hdr2 && is_cpl && (head1[hdr_status_lsb +: 3] == status_ok);
   assign cpl_err  = in_hdr2 && is_cpl && (head1[hdr_status_lsb +: 3] != status_ok);

   // zero length is 1024 dwords, zero byte count is 4096 bytes
   assign len_dw   = (head1[hdr_len_lsb +: 10] == 10'd0) ? 11'd1024
                                                          : {1'b0, head1[hdr_len_lsb +: 10]};
   assign bcount_b = (head1[hdr_bcount_lsb +: 12] == 12'd0) ? 13'd4096
                                                             : {1'b0, head1[hdr_bcount_lsb +: 12]};
   assign low_addr = rd_q[hdr_lowaddr_lsb +: 2];
   assign is_final = ({2'b00, len_dw} == ((bcount_b + 13'(low_addr) + 13'd3) >> 2));

   always_comb begin
      case (low_addr)
         2'd0:    first_be = 4'b1111;
         2'd1:    first_be = 4'b1110;
         2'd2:    first_be = 4'b1100;
         default: first_be = 4'b1000;
      endcase
      // bytes past the end of the request stay masked
      case (low_addr + bcount_b[1:0])
         2'd0:    last_be = 4'b1111;
         2'd1:    last_be = 4'b0001;
         2'd2:    last_be = 4'b0011;
         default: last_be = 4'b0111;
      endcase
      if (!is_final) begin
         last_be = 4'b1111;
      end
   end

   // table access during header2
   assign lookup_tag = rd_q[hdr_tag_lsb +: tag_bits];
   assign upd_v      = cpl_good && !is_final;
   assign upd_tag    = lookup_tag;
   assign upd_addr   = lookup_addr + mem_addr_bits'({len_dw, 2'b00});
   assign free_v     = (cpl_good && is_final) || cpl_err;
   assign free_tag   = lookup_tag;

   assign stat_cpl_inc = cpl_good;
   assign stat_err_inc = cpl_err;

   // ---------------------------------------------------------------------
   // packet FSM
   // ---------------------------------------------------------------------
   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         state <= st_header1;
         op    <= op_drop;
         cmd   <= cmd_none;
      end else begin
         cmd <= cmd_none;
         if (beat_v) begin
            case (state)
               st_header1: begin
                  if (!sof_n_q) begin
                     state <= st_header2;
                  end
               end
               st_header2: begin
                  if (cpl_good) begin
                     cmd <= cmd_first;
                     op  <= lookup_addr[2] ? op_wr_even : op_wr_odd;
                  end else begin
                     op <= op_drop;
                  end
                  state <= eof_n_q ? st_body : st_header1;
               end
               st_body: begin
                  if (op != op_drop) begin
                     cmd <= cmd_body;
                  end
                  if (!eof_n_q) begin
                     state <= st_header1;
                  end
               end
               default: state <= st_header1;
            endcase
         end
      end
   end

   // command payload, only meaningful alongside cmd
   always_ff @(posedge pcie_clk) begin
      cmd_data <= rd_q;
      cmd_last <= !eof_n_q;
      // header2 carries a single dword, a last body beat may too
      cmd_half <= (state == st_header2) || (!eof_n_q && rrem_n_q[3:0] != 4'h0);
      if (beat_v && state == st_header1 && !sof_n_q) begin
         head1 <= rd_q;
      end
      if (cpl_good) begin
         cmd_addr     <= lookup_addr;
         cmd_first_be <= first_be;
         cmd_last_be  <= last_be;
      end
   end

   a_state_legal : assert property (@(posedge pcie_clk) disable iff (rst)
      state inside {st_header1, st_header2, st_body});

endmodule

`default_nettype wire

// File: source/cpl_mem_writer.sv
`timescale 1ns/100ps
`default_nettype none

module cpl_mem_writer #(
   parameter int mem_addr_bits = 16
) (
   input  logic                     pcie_clk,
   input  logic                     rst,
   input  cm_pkg::wr_cmd_t          cmd,
   input  logic [63:0]              cmd_data,
   input  logic [mem_addr_bits-1:0] cmd_addr,
   input  logic [3:0]               cmd_first_be,
   input  logic [3:0]               cmd_last_be,
   input  logic                     cmd_last,
   input  logic                     cmd_half,
   output logic [mem_addr_bits-1:0] wr_addr_hi,
   output logic [31:0]              wr_data_hi,
   output logic [3:0]               wr_mask_hi,
   output logic                     wr_en_hi,
   output logic [mem_addr_bits-1:0] wr_addr_lo,
   output logic [31:0]              wr_data_lo,
   output logic [3:0]               wr_mask_lo,
   output logic                     wr_en_lo
);
   import cm_pkg::*;

   function automatic logic [31:0] swap_bytes(input logic [31:0] dw);
      swap_bytes = {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
   endfunction

   logic [mem_addr_bits-1:0] run_addr;
   logic [mem_addr_bits-1:0] run_addr_p4;
   logic                     phase;
   logic [3:0]               first_mask;
   logic [3:0]               mask0;
   logic [3:0]               mask1;
   logic                     en1;
   logic [31:0]              dw0;
   logic [31:0]              dw1;

   // dword0 sits in the upper half of a body beat, at the lower address
   assign dw0         = swap_bytes(cmd_data[63:32]);
   assign dw1         = swap_bytes(cmd_data[31:0]);
   assign run_addr_p4 = run_addr + mem_addr_bits'(4);

   assign first_mask = cmd_first_be & (cmd_last ? cmd_last_be : 4'b1111);
   assign mask0      = (cmd_last && cmd_half) ? cmd_last_be : 4'b1111;
   assign mask1      = cmd_last ? cmd_last_be : 4'b1111;
   assign en1        = !(cmd_last && cmd_half);

   // ---------------------------------------------------------------------
   // write enables and lane phase
   // ---------------------------------------------------------------------
   // phase 1: first dword went to hi, so body dword0 lands on lo
   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         phase    <= 1'b0;
         wr_en_hi <= 1'b0;
         wr_en_lo <= 1'b0;
      end else begin
         wr_en_hi <= 1'b0;
         wr_en_lo <= 1'b0;
         case (cmd)
            cmd_first: begin
               phase    <= cmd_addr[2];
               wr_en_hi <= cmd_addr[2];
               wr_en_lo <= !cmd_addr[2];
            end
            cmd_body: begin
               wr_en_hi <= phase ? en1 : 1'b1;
               wr_en_lo <= phase ? 1'b1 : en1;
            end
            default: ;
         endcase
      end
   end

   // ---------------------------------------------------------------------
   // address, data and mask
   // ---------------------------------------------------------------------
   always_ff @(posedge pcie_clk) begin
      case (cmd)
         cmd_first: begin
            run_addr   <= cmd_addr + mem_addr_bits'(4);
            wr_addr_hi <= cmd_addr;
            wr_addr_lo <= cmd_addr;
            wr_data_hi <= dw1;
            wr_data_lo <= dw1;
            wr_mask_hi <= first_mask;
            wr_mask_lo <= first_mask;
         end
         cmd_body: begin
            run_addr <= run_addr + mem_addr_bits'(8);
            if (phase) begin
               wr_addr_lo <= run_addr;
               wr_data_lo <= dw0;
               wr_mask_lo <= mask0;
               wr_addr_hi <= run_addr_p4;
               wr_data_hi <= dw1;
               wr_mask_hi <= mask1;
            end else begin
               wr_addr_hi <= run_addr;
               wr_data_hi <= dw0;
               wr_mask_hi <= mask0;
               wr_addr_lo <= run_addr_p4;
               wr_data_lo <= dw1;
               wr_mask_lo <= mask1;
            end
         end
         default: ;
      endcase
   end

   // parser byte enables must never combine to an empty write
   a_mask_nonzero : assert property (@(posedge pcie_clk) disable iff (rst)
      (wr_en_lo |-> wr_mask_lo != 4'h0) and (wr_en_hi |-> wr_mask_hi != 4'h0));

endmodule

`default_nettype wire

// File: source/cm_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module cm_rx_top #(
   parameter int mem_addr_bits = 16
) (
   input  logic                        pcie_clk,
   input  logic                        rst,
   input  logic [63:0]                 trn_rd,
   input  logic [7:0]                  trn_rrem_n,
   input  logic                        trn_rsof_n,
   input  logic                        trn_reof_n,
   input  logic                        trn_rsrc_rdy_n,
   input  logic                        trn_rerrfwd_n,
   input  logic                        ort_req_v,
   input  logic [cm_pkg::tag_bits-1:0] ort_req_tag,
   input  logic [mem_addr_bits-1:0]    ort_req_addr,
   output logic                        cfg_trn_pending_n,
   output logic                        ort_next_tag_v,
   output logic [cm_pkg::tag_bits-1:0] ort_next_tag,
   output logic [mem_addr_bits-1:0]    wr_addr_hi,
   output logic [31:0]                 wr_data_hi,
   output logic [3:0]                  wr_mask_hi,
   output logic                        wr_en_hi,
   output logic [mem_addr_bits-1:0]    wr_addr_lo,
   output logic [31:0]                 wr_data_lo,
   output logic [3:0]                  wr_mask_lo,
   output logic                        wr_en_lo,
   output logic                        stat_cpl_inc,
   output logic                        stat_err_inc
);

   // parser to table
   logic [cm_pkg::tag_bits-1:0] lookup_tag;
   logic [mem_addr_bits-1:0]    lookup_addr;
   logic                        upd_v;
   logic [cm_pkg::tag_bits-1:0] upd_tag;
   logic [mem_addr_bits-1:0]    upd_addr;
   logic                        free_v;
   logic [cm_pkg::tag_bits-1:0] free_tag;

   // parser to writer
   cm_pkg::wr_cmd_t             cmd;
   logic [63:0]                 cmd_data;
   logic [mem_addr_bits-1:0]    cmd_addr;
   logic [3:0]                  cmd_first_be;
   logic [3:0]                  cmd_last_be;
   logic                        cmd_last;
   logic                        cmd_half;

   cpl_parser #(
      .mem_addr_bits (mem_addr_bits)
   ) i_parser (
      .pcie_clk       (pcie_clk),
      .rst            (rst),
      .trn_rd         (trn_rd),
      .trn_rrem_n     (trn_rrem_n),
      .trn_rsof_n     (trn_rsof_n),
      .trn_reof_n     (trn_reof_n),
      .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
      .trn_rerrfwd_n  (trn_rerrfwd_n),
      .lookup_addr    (lookup_addr),
      .lookup_tag     (lookup_tag),
      .upd_v          (upd_v),
      .upd_tag        (upd_tag),
      .upd_addr       (upd_addr),
      .free_v         (free_v),
      .free_tag       (free_tag),
      .cmd            (cmd),
      .cmd_data       (cmd_data),
      .cmd_addr       (cmd_addr),
      .cmd_first_be   (cmd_first_be),
      .cmd_last_be    (cmd_last_be),
      .cmd_last       (cmd_last),
      .cmd_half       (cmd_half),
      .stat_cpl_inc   (stat_cpl_inc),
      .stat_err_inc   (stat_err_inc)
   );

   ort_table #(
      .mem_addr_bits (mem_addr_bits)
   ) i_ort (
      .pcie_clk          (pcie_clk),
      .rst               (rst),
      .ort_req_v         (ort_req_v),
      .ort_req_tag       (ort_req_tag),
      .ort_req_addr      (ort_req_addr),
      .lookup_tag        (lookup_tag),
      .upd_v             (upd_v),
      .upd_tag           (upd_tag),
      .upd_addr          (upd_addr),
      .free_v            (free_v),
      .free_tag          (free_tag),
      .lookup_addr       (lookup_addr),
      .ort_next_tag_v    (ort_next_tag_v),
      .ort_next_tag      (ort_next_tag),
      .cfg_trn_pending_n (cfg_trn_pending_n)
   );

   cpl_mem_writer #(
      .mem_addr_bits (mem_addr_bits)
   ) i_writer (
      .pcie_clk     (pcie_clk),
      .rst          (rst),
      .cmd          (cmd),
      .cmd_data     (cmd_data),
      .cmd_addr     (cmd_addr),
      .cmd_first_be (cmd_first_be),
      .cmd_last_be  (cmd_last_be),
      .cmd_last     (cmd_last),
      .cmd_half     (cmd_half),
      .wr_addr_hi   (wr_addr_hi),
      .wr_data_hi   (wr_data_hi),
      .wr_mask_hi   (wr_mask_hi),
      .wr_en_hi     (wr_en_hi),
      .wr_addr_lo   (wr_addr_lo),
      .wr_data_lo   (wr_data_lo),
      .wr_mask_lo   (wr_mask_lo),
      .wr_en_lo     (wr_en_lo)
   );

endmodule

`default_nettype wire

// File: testbench/cm_rx_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cm_rx_checker #(
   parameter int mem_addr_bits = 16
) (
   input  logic                     pcie_clk,
   input  logic                     rst,
   input  logic [mem_addr_bits-1:0] wr_addr_hi,
   input  logic [31:0]              wr_data_hi,
   input  logic [3:0]               wr_mask_hi,
   input  logic                     wr_en_hi,
   input  logic [mem_addr_bits-1:0] wr_addr_lo,
   input  logic [31:0]              wr_data_lo,
   input  logic [3:0]               wr_mask_lo,
   input  logic                     wr_en_lo,
   input  logic                     stat_cpl_inc,
   input  logic                     stat_err_inc,
   input  logic                     cfg_trn_pending_n,
   input  logic                     ort_next_tag_v,
   input  logic [3:0]               ort_next_tag
);

   logic [7:0]               dut_mem [2**mem_addr_bits];
   logic [7:0]               exp_mem [2**mem_addr_bits];
   logic [31:0]              pay [1024];
   logic [15:0]              m_valid = '0;
   logic [mem_addr_bits-1:0] m_addr [16];
   int dut_writes = 0;
   int exp_writes = 0;
   int dut_cpl    = 0;
   int exp_cpl    = 0;
   int dut_err    = 0;
   int exp_err    = 0;

   // same fill pattern in both memories
   initial begin
      for (int a = 0; a < 2**mem_addr_bits; a++) begin
         dut_mem[a] = 8'(a ^ (a >> 8) ^ 8'h5a);
         exp_mem[a] = dut_mem[a];
      end
   end

   // ---------------------------------------------------------------------
   // mirror of the DUT write ports
   // ---------------------------------------------------------------------
   task automatic store(input logic [mem_addr_bits-1:0] addr, input logic [31:0] data,
                        input logic [3:0] mask);
      for (int i = 0; i < 4; i++) begin
         if (mask[i]) begin
            dut_mem[addr + mem_addr_bits'(i)] = data[8*i +: 8];
         end
      end
      dut_writes++;
   endtask

   always @(negedge pcie_clk) begin
      if (!rst) begin
         if (wr_en_lo) begin
            store(wr_addr_lo, wr_data_lo, wr_mask_lo);
         end
         if (wr_en_hi) begin
            store(wr_addr_hi, wr_data_hi, wr_mask_hi);
         end
         if (stat_cpl_inc) begin
            dut_cpl++;
         end
         if (stat_err_inc) begin
            dut_err++;
         end
      end
   end

   // ---------------------------------------------------------------------
   // reference model
   // ---------------------------------------------------------------------
   task automatic model_request(input logic [3:0] tag, input logic [mem_addr_bits-1:0] addr);
      m_valid[tag] = 1'b1;
      m_addr[tag]  = addr;
   endtask

   // kind 0 good completion, 1 error completion, 2 other packet
   task automatic model_cpl(input int kind, input logic [3:0] tag, input logic [1:0] low,
                            input int bcount, input int len);
      logic [mem_addr_bits-1:0] base;
      int                       last;
      logic                     fin;
      base = m_addr[tag];
      fin  = (len == (bcount + low + 3) / 4);
      if (kind == 0) begin
         // payload is big endian within each dword
         last = fin ? low + bcount : 4 * len;
         for (int j = low; j < last; j++) begin
            exp_mem[base + mem_addr_bits'(j)] = 8'(pay[j / 4] >> (24 - 8 * (j % 4)));
         end
         exp_writes += len;
         exp_cpl++;
         if (fin) begin
            m_valid[tag] = 1'b0;
         end else begin
            m_addr[tag] = base + mem_addr_bits'(4 * len);
         end
      end else if (kind == 1) begin
         exp_err++;
         m_valid[tag] = 1'b0;
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got,
                            inout int errs);
      if (exp !== got) begin
         $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
         errs++;
      end
   endtask

   task automatic compare(output int errs);
      logic [3:0] exp_tag;
      logic       exp_v;
      errs    = 0;
      exp_v   = 1'b0;
      exp_tag = '0;
      for (int i = 0; i < 16; i++) begin
         if (!m_valid[i]) begin
            exp_v   = 1'b1;
            exp_tag = 4'(i);
         end
      end
      check_val("ort_next_tag_v", exp_v, ort_next_tag_v, errs);
      if (exp_v) begin
         check_val("ort_next_tag", exp_tag, ort_next_tag, errs);
      end
      check_val("cfg_trn_pending_n", ~|m_valid, cfg_trn_pending_n, errs);
      check_val("stat_cpl_inc count", exp_cpl, dut_cpl, errs);
      check_val("stat_err_inc count", exp_err, dut_err, errs);
      check_val("write count", exp_writes, dut_writes, errs);
      for (int a = 0; a < 2**mem_addr_bits; a++) begin
         if (dut_mem[a] !== exp_mem[a]) begin
            if (errs < 8) begin
               $display("** Error: mem[0x%h] expected 0x%h got 0x%h", a[15:0], exp_mem[a],
                        dut_mem[a]);
            end
            errs++;
         end
      end
   endtask

endmodule

`default_nettype wire

// File: testbench/tb_cm_rx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cm_rx;
   import cm_pkg::*;

   localparam int mem_addr_bits = 16;

   logic                     pcie_clk;
   logic                     rst;
   logic [63:0]              trn_rd;
   logic [7:0]               trn_rrem_n;
   logic                     trn_rsof_n;
   logic                     trn_reof_n;
   logic                     trn_rsrc_rdy_n;
   logic                     trn_rerrfwd_n;
   logic                     ort_req_v;
   logic [3:0]               ort_req_tag;
   logic [mem_addr_bits-1:0] ort_req_addr;
   logic                     cfg_trn_pending_n;
   logic                     ort_next_tag_v;
   logic [3:0]               ort_next_tag;
   logic [mem_addr_bits-1:0] wr_addr_hi;
   logic [mem_addr_bits-1:0] wr_addr_lo;
   logic [31:0]              wr_data_hi;
   logic [31:0]              wr_data_lo;
   logic [3:0]               wr_mask_hi;
   logic [3:0]               wr_mask_lo;
   logic                     wr_en_hi;
   logic                     wr_en_lo;
   logic                     stat_cpl_inc;
   logic                     stat_err_inc;

   integer seed = 32'h8cbe;
   int     test_errs = 0;
   int     n_pass = 0;
   int     n_fail = 0;

   cm_rx_top #(.mem_addr_bits(mem_addr_bits)) i_dut (.*);

   cm_rx_checker #(.mem_addr_bits(mem_addr_bits)) i_chk (
      .pcie_clk (pcie_clk), .rst (rst),
      .wr_addr_hi (wr_addr_hi), .wr_data_hi (wr_data_hi),
      .wr_mask_hi (wr_mask_hi), .wr_en_hi (wr_en_hi),
      .wr_addr_lo (wr_addr_lo), .wr_data_lo (wr_data_lo),
      .wr_mask_lo (wr_mask_lo), .wr_en_lo (wr_en_lo),
      .stat_cpl_inc (stat_cpl_inc), .stat_err_inc (stat_err_inc),
      .cfg_trn_pending_n (cfg_trn_pending_n),
      .ort_next_tag_v (ort_next_tag_v), .ort_next_tag (ort_next_tag)
   );

   initial begin
      pcie_clk = 1'b0;
      forever #2 pcie_clk = ~pcie_clk;
   end

   // ---------------------------------------------------------------------
   // receive stream driving
   // ---------------------------------------------------------------------
   task automatic idle(input int n);
      repeat (n) begin
         @(posedge pcie_clk);
         trn_rsrc_rdy_n <= 1'b1;
         trn_rsof_n     <= 1'b1;
         trn_reof_n     <= 1'b1;
      end
   endtask

   task automatic beat(input logic [63:0] data, input logic sof, input logic eof,
                       input logic [7:0] rrem_n);
      @(posedge pcie_clk);
      trn_rd         <= data;
      trn_rsof_n     <= !sof;
      trn_reof_n     <= !eof;
      trn_rrem_n     <= rrem_n;
      trn_rsrc_rdy_n <= 1'b0;
   endtask

   task automatic fill_payload(input int len);
      for (int k = 0; k < len; k++) begin
         i_chk.pay[k] = $random(seed);
      end
   endtask

   // kind 0 good completion, 1 error completion, 2 memory write (not a completion)
   task automatic send_pkt(input int kind, input logic [3:0] tag, input logic [1:0] low,
                           input int bcount, input int len);
      logic [63:0] h1;
      logic [63:0] h2;
      int          k;
      h1 = '0;
      h2 = '0;
      h1[hdr_fmt_lsb +: 2]     = (kind == 2) ? 2'b11 : 2'b10;
      h1[hdr_type_lsb +: 5]    = (kind == 2) ? 5'b00000 : 5'b01010;
      h1[hdr_status_lsb +: 3]  = (kind == 1) ? 3'b001 : 3'b000;
      h1[hdr_len_lsb +: 10]    = 10'(len);
      h1[hdr_bcount_lsb +: 12] = 12'(bcount);
      h2[hdr_tag_lsb +: 4]     = tag;
      h2[hdr_lowaddr_lsb +: 2] = low;
      h2[31:0]                 = i_chk.pay[0];
      i_chk.model_cpl(kind, tag, low, bcount, len);
      beat(h1, 1'b1, 1'b0, 8'h00);
      beat(h2, 1'b0, len == 1, 8'h00);
      k = 1;
      while (k < len) begin
         if (k + 1 < len) begin
            beat({i_chk.pay[k], i_chk.pay[k+1]}, 1'b0, k + 2 >= len, 8'h00);
         end else begin
            // lone dword in the upper half
            beat({i_chk.pay[k], 32'h0}, 1'b0, 1'b1, 8'h0f);
         end
         k += 2;
      end
   endtask

   task automatic request_tag(input logic [mem_addr_bits-1:0] addr, output logic [3:0] tag);
      int t;
      t = 0;
      @(negedge pcie_clk);
      while (!ort_next_tag_v && t < 200) begin
         @(negedge pcie_clk);
         t++;
      end
      if (!ort_next_tag_v) begin
         $display("timeout: the ORT never offered a free tag");
         test_errs++;
      end
      tag = ort_next_tag;
      @(posedge pcie_clk);
      ort_req_v      <= 1'b1;
      ort_req_tag    <= tag;
      ort_req_addr   <= addr;
      trn_rsrc_rdy_n <= 1'b1;
      i_chk.model_request(tag, addr);
      @(posedge pcie_clk);
      ort_req_v <= 1'b0;
   endtask

   // wait until the DUT has caught up with the model
   task automatic wait_idle();
      int t;
      t = 0;
      idle(1);
      @(negedge pcie_clk);
      while (t < 1000 && !(i_chk.dut_writes == i_chk.exp_writes
             && i_chk.dut_cpl == i_chk.exp_cpl && i_chk.dut_err == i_chk.exp_err
             && cfg_trn_pending_n == ~|i_chk.m_valid)) begin
         @(negedge pcie_clk);
         t++;
      end
      if (t >= 1000) begin
         $display("timeout: DUT writes and statistics did not settle");
         test_errs++;
      end
   endtask

   task automatic check_now();
      int e;
      i_chk.compare(e);
      test_errs += e;
   endtask

   task automatic finish_test(input string name);
      check_now();
      if (test_errs == 0) begin
         $display("test %s: pass", name);
         n_pass++;
      end else begin
         $display("test %s: fail, %0d errors", name, test_errs);
         n_fail++;
      end
      test_errs = 0;
   endtask

   // ---------------------------------------------------------------------
   // test sequence
   // ---------------------------------------------------------------------
   initial begin
      logic [3:0] ta;
      logic [3:0] tb;
      logic [3:0] tc;
      logic [3:0] tag;
      logic [1:0] low;
      int         kind;
      int         bcount;
      int         len;
      int         rest;
      rst = 1'b1;
      trn_rd = '0;
      trn_rrem_n = '0;
      trn_rsof_n = 1'b1;
      trn_reof_n = 1'b1;
      trn_rsrc_rdy_n = 1'b1;
      trn_rerrfwd_n = 1'b1;
      ort_req_v = 1'b0;
      ort_req_tag = '0;
      ort_req_addr = '0;
      repeat (4) @(posedge pcie_clk);
      rst <= 1'b0;
      @(negedge pcie_clk);
      finish_test("reset state");

      request_tag(16'h1000, ta);
      wait_idle();
      check_now();
      request_tag(16'h2000, tb);
      wait_idle();
      check_now();
      request_tag(16'h3004, tc);
      wait_idle();
      finish_test("tag allocation");

      // odd dword start address puts the first dword on the hi lane
      fill_payload(4);
      send_pkt(0, tc, 2'd1, 13, 4);
      wait_idle();
      finish_test("single good completion");

      // 40 bytes from offset 2 split after five dwords
      fill_payload(5);
      send_pkt(0, tb, 2'd2, 40, 5);
      wait_idle();
      check_now();
      fill_payload(6);
      send_pkt(0, tb, 2'd0, 22, 6);
      wait_idle();
      finish_test("split completion");

      // unknown packet names the only valid tag
      fill_payload(2);
      send_pkt(2, ta, 2'd0, 8, 2);
      wait_idle();
      check_now();
      send_pkt(1, ta, 2'd0, 8, 2);
      wait_idle();
      finish_test("error and unknown packets");

      for (int n = 0; n < 200; n++) begin
         kind   = $unsigned($random(seed)) % 8;
         low    = 2'($random(seed));
         bcount = 1 + $unsigned($random(seed)) % 48;
         len    = (bcount + low + 3) / 4;
         fill_payload(len);
         if (kind == 6) begin
            send_pkt(2, 4'h0, low, bcount, len);
         end else begin
            request_tag(16'($random(seed)) & 16'hfffc, tag);
            if (kind == 7 && len > 1) begin
               send_pkt(0, tag, low, bcount, len - 1);
               rest = bcount - (4 * (len - 1) - low);
               fill_payload((rest + 3) / 4);
               send_pkt(0, tag, 2'd0, rest, (rest + 3) / 4);
            end else begin
               send_pkt(kind >= 5 ? 1 : 0, tag, low, bcount, len);
            end
         end
         idle($unsigned($random(seed)) % 4);
      end
      wait_idle();
      finish_test("random mix");

      $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
source/cm_pkg.sv
source/ort_table.sv
source/cpl_parser.sv
source/cpl_mem_writer.sv
source/cm_rx_top.sv
testbench/cm_rx_checker.sv
testbench/tb_cm_rx.sv
